/* Makefile */
TOP = tb_arc_support

.PHONY: lint sim clean

lint:
	verilator --lint-only --timescale 1ns/1ps --top-module arc_support_top \
		arc_support_pkg.sv pll_reconfig_seq.sv back_porch_blank.sv \
		mem_loader_arbiter.sv arc_support_top.sv

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f arc_support.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* arc_support.f */
+incdir+.
arc_support_pkg.sv
pll_reconfig_seq.sv
back_porch_blank.sv
mem_loader_arbiter.sv
arc_support_top.sv
tb_arc_support.sv

/* arc_support_pkg.sv */
package arc_support_pkg;

	// video base-clock select from the core
	// 01 is the 25 MHz family, 10 is 36 MHz, the rest 24 MHz
	typedef logic [1:0] clk_sel_t;

	// one colour channel of the core's video
	typedef logic [3:0] colour_t;

	// data loader image index and byte address
	typedef logic [7:0] dio_index_t;
	typedef logic [23:0] loader_addr_t;

	// core word address, byte address bits 26 down to 2
	typedef logic [24:0] core_addr_t;

	// ram byte address, always word aligned
	typedef logic [25:0] ram_addr_t;

	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_sel_t;

	// pll reconfiguration sequencer states
	typedef enum logic [1:0] {
		RCFG_IDLE,
		RCFG_SETTLE,
		RCFG_WAIT_IDLE,
		RCFG_RUN
	} reconfig_state_t;

	// rom images owned by the loader
	localparam dio_index_t IDX_ROM_A = 8'd1;
	localparam dio_index_t IDX_ROM_B = 8'd2;

	// cmos ram image
	localparam dio_index_t IDX_CMOS = 8'd3;

	// the pll comes up in the 36 MHz family
	localparam clk_sel_t CLK_SEL_RESET = 2'b10;

endpackage

/* arc_support_top.sv */
`timescale 1ns/1ps

module arc_support_top
	import arc_support_pkg::*;
#(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic         clk_sys,
	input  logic         arst_n_i,

	// shared by the sequencer and the blanking
	input  clk_sel_t     clk_sel_i,

	// pixel pll reconfiguration
	input  logic         reconfig_busy_i,
	input  logic         rom_q24_i,
	input  logic         rom_q25_i,
	input  logic         rom_q36_i,
	output logic         vid_clk_ena_o,
	output logic         write_from_rom_o,
	output logic         reconfig_o,
	output logic         reconfig_reset_o,
	output logic         rom_q_o,

	// video
	input  logic         ce_pix_i,
	input  logic         scandoubler_disable_i,
	input  logic         hs_i,
	input  logic         vs_i,
	input  colour_t      r_i,
	input  colour_t      g_i,
	input  colour_t      b_i,
	output logic         hs_o,
	output logic         vs_o,
	output colour_t      r_o,
	output colour_t      g_o,
	output colour_t      b_o,
	output logic         scandoubler_en_o,

	// loader
	input  logic         downloading_i,
	input  logic         uploading_i,
	input  dio_index_t   dio_index_i,
	input  logic         loader_we_i,
	input  loader_addr_t loader_addr_i,
	input  byte_sel_t    loader_sel_i,
	input  word_t        loader_data_i,

	// core bus
	input  logic         core_stb_i,
	input  logic         core_we_i,
	input  byte_sel_t    core_sel_i,
	input  core_addr_t   core_addr_i,
	input  word_t        core_data_i,
	output logic         core_ack_o,

	// ram and board
	input  logic         ram_ack_i,
	input  logic         ram_ready_i,
	input  logic         reset_button_i,
	output logic         ram_stb_o,
	output logic         ram_cyc_o,
	output logic         ram_we_o,
	output byte_sel_t    ram_sel_o,
	output ram_addr_t    ram_addr_o,
	output word_t        ram_data_o,
	output logic         rom_ready_o,
	output logic         core_reset_o,
	output logic         cmos_we_o,
	output logic         cmos_rd_o
);

	pll_reconfig_seq #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) pll_reconfig_seq_i (
		.clk_sys          (clk_sys),
		.arst_n_i         (arst_n_i),
		.clk_sel_i        (clk_sel_i),
		.reconfig_busy_i  (reconfig_busy_i),
		.write_from_rom_o (write_from_rom_o),
		.reconfig_o       (reconfig_o),
		.reconfig_reset_o (reconfig_reset_o),
		.vid_clk_ena_o    (vid_clk_ena_o),
		.rom_q24_i        (rom_q24_i),
		.rom_q25_i        (rom_q25_i),
		.rom_q36_i        (rom_q36_i),
		.rom_q_o          (rom_q_o)
	);

	back_porch_blank back_porch_blank_i (
		.clk_sys               (clk_sys),
		.arst_n_i              (arst_n_i),
		.ce_pix_i              (ce_pix_i),
		.clk_sel_i             (clk_sel_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.hs_i                  (hs_i),
		.vs_i                  (vs_i),
		.r_i                   (r_i),
		.g_i                   (g_i),
		.b_i                   (b_i),
		.hs_o                  (hs_o),
		.vs_o                  (vs_o),
		.r_o                   (r_o),
		.g_o                   (g_o),
		.b_o                   (b_o),
		.scandoubler_en_o      (scandoubler_en_o)
	);

	mem_loader_arbiter mem_loader_arbiter_i (
		.clk_sys        (clk_sys),
		.arst_n_i       (arst_n_i),
		.downloading_i  (downloading_i),
		.uploading_i    (uploading_i),
		.dio_index_i    (dio_index_i),
		.loader_we_i    (loader_we_i),
		.loader_addr_i  (loader_addr_i),
		.loader_sel_i   (loader_sel_i),
		.loader_data_i  (loader_data_i),
		.core_stb_i     (core_stb_i),
		.core_we_i      (core_we_i),
		.core_sel_i     (core_sel_i),
		.core_addr_i    (core_addr_i),
		.core_data_i    (core_data_i),
		.core_ack_o     (core_ack_o),
		.ram_stb_o      (ram_stb_o),
		.ram_cyc_o      (ram_cyc_o),
		.ram_we_o       (ram_we_o),
		.ram_sel_o      (ram_sel_o),
		.ram_addr_o     (ram_addr_o),
		.ram_data_o     (ram_data_o),
		.ram_ack_i      (ram_ack_i),
		.ram_ready_i    (ram_ready_i),
		.reset_button_i (reset_button_i),
		.rom_ready_o    (rom_ready_o),
		.core_reset_o   (core_reset_o),
		.cmos_we_o      (cmos_we_o),
		.cmos_rd_o      (cmos_rd_o)
	);

endmodule

/* back_porch_blank.sv */
`timescale 1ns/1ps

module back_porch_blank
	import arc_support_pkg::*;
(
	input  logic     clk_sys,
	input  logic     arst_n_i,

	// pixel clock enable from the core
	input  logic     ce_pix_i,

	input  clk_sel_t clk_sel_i,
	input  logic     scandoubler_disable_i,

	// raw core video
	input  logic     hs_i,
	input  logic     vs_i,
	input  colour_t  r_i,
	input  colour_t  g_i,
	input  colour_t  b_i,

	// registered and blanked video
	output logic     hs_o,
	output logic     vs_o,
	output colour_t  r_o,
	output colour_t  g_o,
	output colour_t  b_o,

	output logic     scandoubler_en_o
);

	logic [7:0] blank_cnt;
	logic       tv_mode;
	logic       porch_done;

	// 15 kHz modes use matching select bits
	assign tv_mode = (clk_sel_i[0] == clk_sel_i[1]);

	// window is 256 cycles in tv mode, 64 for vga
	assign porch_done = tv_mode ? &blank_cnt : &blank_cnt[5:0];

	assign scandoubler_en_o = !scandoubler_disable_i && tv_mode;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			blank_cnt <= '0;
			hs_o <= 1'b0;
			vs_o <= 1'b0;
			r_o <= '0;
			g_o <= '0;
			b_o <= '0;
		end else begin
			// restart the window during hsync
			if (!hs_o)
				blank_cnt <= '0;
			else if (!porch_done)
				blank_cnt <= blank_cnt + 1'b1;

			if (ce_pix_i) begin
				hs_o <= hs_i;
				vs_o <= vs_i;
				r_o <= porch_done ? r_i : '0;
				g_o <= porch_done ? g_i : '0;
				b_o <= porch_done ? b_i : '0;
			end
		end
	end

endmodule

/* mem_loader_arbiter.sv */
`timescale 1ns/1ps

module mem_loader_arbiter
	import arc_support_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n_i,

	// data loader
	input  logic         downloading_i,
	input  logic         uploading_i,
	input  dio_index_t   dio_index_i,
	input  logic         loader_we_i,
	input  loader_addr_t loader_addr_i,
	input  byte_sel_t    loader_sel_i,
	input  word_t        loader_data_i,

	// core memory bus
	input  logic         core_stb_i,
	input  logic         core_we_i,
	input  byte_sel_t    core_sel_i,
	input  core_addr_t   core_addr_i,
	input  word_t        core_data_i,
	output logic         core_ack_o,

	// ram port
	output logic         ram_stb_o,
	output logic         ram_cyc_o,
	output logic         ram_we_o,
	output byte_sel_t    ram_sel_o,
	output ram_addr_t    ram_addr_o,
	output word_t        ram_data_o,
	input  logic         ram_ack_i,
	input  logic         ram_ready_i,

	// board and system
	input  logic         reset_button_i,
	output logic         rom_ready_o,
	output logic         core_reset_o,

	// cmos image strobes
	output logic         cmos_we_o,
	output logic         cmos_rd_o
);

	logic loader_active;
	logic loader_active_q;
	logic loader_stb;

	assign loader_active = downloading_i &&
		(dio_index_i == IDX_ROM_A || dio_index_i == IDX_ROM_B);

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			loader_active_q <= 1'b0;
			loader_stb <= 1'b0;
			rom_ready_o <= 1'b0;
		end else begin
			loader_active_q <= loader_active;

			// roms are in place once the first load finishes
			if (loader_active_q && !loader_active)
				rom_ready_o <= 1'b1;

			// keep the strobe up until the ram acknowledges
			if (loader_we_i)
				loader_stb <= 1'b1;
			else if (ram_ack_i)
				loader_stb <= 1'b0;
		end
	end

	always_comb begin
		if (loader_active) begin
			ram_we_o = 1'b1;
			ram_sel_o = loader_sel_i;
			ram_addr_o = {2'b00, loader_addr_i[23:2], 2'b00};
			ram_data_o = loader_data_i;
			ram_stb_o = loader_stb;
			ram_cyc_o = loader_stb;
			core_ack_o = 1'b0;
		end else begin
			ram_we_o = core_we_i;
			ram_sel_o = core_sel_i;
			// core sees the low 16 MB of ram
			ram_addr_o = {2'b00, core_addr_i[21:0], 2'b00};
			ram_data_o = core_data_i;
			ram_stb_o = core_stb_i;
			ram_cyc_o = core_stb_i;
			core_ack_o = ram_ack_i;
		end
	end

	assign core_reset_o = !ram_ready_i || !rom_ready_o || reset_button_i;

	assign cmos_we_o = downloading_i && (dio_index_i == IDX_CMOS) && loader_we_i;
	assign cmos_rd_o = uploading_i && (dio_index_i == IDX_CMOS);

endmodule

/* pll_reconfig_seq.sv */
`timescale 1ns/1ps

module pll_reconfig_seq
	import arc_support_pkg::*;
#(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic     clk_sys,
	input  logic     arst_n_i,

	// requested base clock from the core
	input  clk_sel_t clk_sel_i,

	// reconfiguration engine
	input  logic     reconfig_busy_i,
	output logic     write_from_rom_o,
	output logic     reconfig_o,
	output logic     reconfig_reset_o,

	// gate for the video clock buffers
	output logic     vid_clk_ena_o,

	// parameter rom data, one rom per clock family
	input  logic     rom_q24_i,
	input  logic     rom_q25_i,
	input  logic     rom_q36_i,
	output logic     rom_q_o
);

	localparam int CNT_W = $clog2(RECONFIG_TIMEOUT + 1);

	reconfig_state_t  state;
	clk_sel_t         sel_q;
	logic [CNT_W-1:0] timeout_cnt;

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= RCFG_IDLE;
			sel_q <= CLK_SEL_RESET;
			timeout_cnt <= '0;
			vid_clk_ena_o <= 1'b0;
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconfig_reset_o <= 1'b0;
		end else begin
			// engine controls are single cycle pulses
			write_from_rom_o <= 1'b0;
			reconfig_o <= 1'b0;
			reconfig_reset_o <= 1'b0;

			case (state)
			RCFG_IDLE: begin
				vid_clk_ena_o <= 1'b1;
				sel_q <= clk_sel_i;
				if (clk_sel_i != sel_q) begin
					// stop the video clock while the pll is rewritten
					vid_clk_ena_o <= 1'b0;
					write_from_rom_o <= 1'b1;
					state <= RCFG_SETTLE;
				end
			end

			// give the engine a cycle to pick up the rom write
			RCFG_SETTLE: state <= RCFG_WAIT_IDLE;

			RCFG_WAIT_IDLE: begin
				if (!reconfig_busy_i) begin
					reconfig_o <= 1'b1;
					// reset pulse lands timeout-1 cycles after reconfig
					timeout_cnt <= CNT_W'(RECONFIG_TIMEOUT - 1);
					state <= RCFG_RUN;
				end
			end

			RCFG_RUN: begin
				timeout_cnt <= timeout_cnt - 1'b1;
				// engine stuck busy, kick it with a reset
				if (timeout_cnt == CNT_W'(1)) begin
					reconfig_reset_o <= 1'b1;
					state <= RCFG_IDLE;
				end
				if (!reconfig_o && !reconfig_busy_i)
					state <= RCFG_IDLE;
			end

			default: state <= RCFG_IDLE;
			endcase
		end
	end

	// rom bit for the family being requested
	always_comb begin
		case (clk_sel_i)
		2'b01:   rom_q_o = rom_q25_i;
		2'b10:   rom_q_o = rom_q36_i;
		default: rom_q_o = rom_q24_i;
		endcase
	end

endmodule

/* tb_arc_support_checks.svh */
`ifndef TB_ARC_SUPPORT_CHECKS_SVH
`define TB_ARC_SUPPORT_CHECKS_SVH

// error counts, one per kind of result
int err_bit = 0;
int err_colour = 0;
int err_addr = 0;
int err_word = 0;
int err_sel = 0;
int err_other = 0;

task automatic check_bit(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		err_bit++;
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_colour(input string what, input colour_t got, input colour_t exp);
	if (got !== exp) begin
		err_colour++;
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_ram_addr(input string what, input ram_addr_t got, input ram_addr_t exp);
	if (got !== exp) begin
		err_addr++;
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_word(input string what, input word_t got, input word_t exp);
	if (got !== exp) begin
		err_word++;
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

// byte lanes on the ram port
task automatic check_sel(input string what, input byte_sel_t got, input byte_sel_t exp);
	if (got !== exp) begin
		err_sel++;
		$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

function automatic int total_errors();
	return err_bit + err_colour + err_addr + err_word + err_sel + err_other;
endfunction

task automatic report_counts();
	$display("errors: bit %0d colour %0d addr %0d word %0d sel %0d other %0d total %0d",
		err_bit, err_colour, err_addr, err_word, err_sel, err_other, total_errors());
endtask

`endif

/* tb_arc_support.sv */
`timescale 1ns/1ps

module tb_arc_support
	import arc_support_pkg::*;
;

	localparam int RECONFIG_TIMEOUT = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SEQ_CYCLES = 6000;
	localparam int TIMEOUT_RUNS = 4;
	localparam int LOAD_CYCLES = 2000;
	localparam int CMOS_CYCLES = 400;
	localparam int CORE_CYCLES = 3000;
	// phase lengths plus margin, comes to 20000
	localparam int MAX_CYCLES = RESET_CYCLES + SEQ_CYCLES + TIMEOUT_RUNS * 3 * RECONFIG_TIMEOUT
		+ 2 * LOAD_CYCLES + 2 * CMOS_CYCLES + CORE_CYCLES + 5710;

	logic clk_sys;
	logic arst_n_i;
	clk_sel_t clk_sel_i;
	logic reconfig_busy_i, rom_q24_i, rom_q25_i, rom_q36_i;
	logic vid_clk_ena_o, write_from_rom_o, reconfig_o, reconfig_reset_o, rom_q_o;
	logic ce_pix_i, scandoubler_disable_i, hs_i, vs_i;
	colour_t r_i, g_i, b_i, r_o, g_o, b_o;
	logic hs_o, vs_o, scandoubler_en_o;
	logic downloading_i, uploading_i, loader_we_i;
	dio_index_t dio_index_i;
	loader_addr_t loader_addr_i;
	byte_sel_t loader_sel_i, core_sel_i, ram_sel_o;
	word_t loader_data_i, core_data_i, ram_data_o;
	logic core_stb_i, core_we_i, core_ack_o;
	core_addr_t core_addr_i;
	logic ram_ack_i, ram_ready_i, reset_button_i;
	logic ram_stb_o, ram_cyc_o, ram_we_o;
	ram_addr_t ram_addr_o;
	logic rom_ready_o, core_reset_o, cmos_we_o, cmos_rd_o;

	// model state
	reconfig_state_t m_state;
	clk_sel_t m_sel;
	int m_age;
	logic m_vid, m_wr, m_rcfg, m_rrst;
	logic [7:0] m_cnt;
	logic m_hs, m_vs;
	colour_t m_r, m_g, m_b;
	logic m_stb, m_act_q, m_rdy;

	int seed = 32'h4831eb7c;
	int cycles = 0;

	`include "tb_arc_support_checks.svh"

	arc_support_top #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) arc_support_top_i (
		.clk_sys(clk_sys), .arst_n_i(arst_n_i), .clk_sel_i(clk_sel_i),
		.reconfig_busy_i(reconfig_busy_i), .rom_q24_i(rom_q24_i), .rom_q25_i(rom_q25_i),
		.rom_q36_i(rom_q36_i), .vid_clk_ena_o(vid_clk_ena_o),
		.write_from_rom_o(write_from_rom_o), .reconfig_o(reconfig_o),
		.reconfig_reset_o(reconfig_reset_o), .rom_q_o(rom_q_o),
		.ce_pix_i(ce_pix_i), .scandoubler_disable_i(scandoubler_disable_i),
		.hs_i(hs_i), .vs_i(vs_i), .r_i(r_i), .g_i(g_i), .b_i(b_i),
		.hs_o(hs_o), .vs_o(vs_o), .r_o(r_o), .g_o(g_o), .b_o(b_o),
		.scandoubler_en_o(scandoubler_en_o),
		.downloading_i(downloading_i), .uploading_i(uploading_i), .dio_index_i(dio_index_i),
		.loader_we_i(loader_we_i), .loader_addr_i(loader_addr_i),
		.loader_sel_i(loader_sel_i), .loader_data_i(loader_data_i),
		.core_stb_i(core_stb_i), .core_we_i(core_we_i), .core_sel_i(core_sel_i),
		.core_addr_i(core_addr_i), .core_data_i(core_data_i), .core_ack_o(core_ack_o),
		.ram_ack_i(ram_ack_i), .ram_ready_i(ram_ready_i), .reset_button_i(reset_button_i),
		.ram_stb_o(ram_stb_o), .ram_cyc_o(ram_cyc_o), .ram_we_o(ram_we_o),
		.ram_sel_o(ram_sel_o), .ram_addr_o(ram_addr_o), .ram_data_o(ram_data_o),
		.rom_ready_o(rom_ready_o), .core_reset_o(core_reset_o),
		.cmos_we_o(cmos_we_o), .cmos_rd_o(cmos_rd_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// true with a chance of one in n
	function automatic logic chance(input int n);
		return ($random(seed) % n) == 0;
	endfunction

	// 15 kHz modes have both select bits equal
	function automatic logic tv_mode(input clk_sel_t sel);
		return sel[0] == sel[1];
	endfunction

	function automatic logic window_done(input logic [7:0] cnt);
		return tv_mode(clk_sel_i) ? (cnt == 8'hff) : (cnt[5:0] == 6'h3f);
	endfunction

	function automatic logic family_rom_bit();
		if (clk_sel_i == 2'b01)
			return rom_q25_i;
		if (clk_sel_i == 2'b10)
			return rom_q36_i;
		return rom_q24_i;
	endfunction

	function automatic logic loader_owns();
		return downloading_i && (dio_index_i == IDX_ROM_A || dio_index_i == IDX_ROM_B);
	endfunction

	// sequencer model, age counts edges since the reconfig pulse
	always @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			m_state <= RCFG_IDLE;
			m_sel <= CLK_SEL_RESET;
			m_age <= 0;
			m_vid <= 1'b0;
			m_wr <= 1'b0;
			m_rcfg <= 1'b0;
			m_rrst <= 1'b0;
		end else begin
			m_wr <= 1'b0;
			m_rcfg <= 1'b0;
			m_rrst <= 1'b0;
			case (m_state)
			RCFG_IDLE: begin
				m_sel <= clk_sel_i;
				m_vid <= (clk_sel_i == m_sel);
				if (clk_sel_i != m_sel) begin
					m_wr <= 1'b1;
					m_state <= RCFG_SETTLE;
				end
			end
			RCFG_SETTLE: m_state <= RCFG_WAIT_IDLE;
			RCFG_WAIT_IDLE: begin
				if (!reconfig_busy_i) begin
					m_rcfg <= 1'b1;
					m_age <= 0;
					m_state <= RCFG_RUN;
				end
			end
			RCFG_RUN: begin
				m_age <= m_age + 1;
				if (m_age + 1 == RECONFIG_TIMEOUT - 1) begin
					m_rrst <= 1'b1;
					m_state <= RCFG_IDLE;
				end
				if (!m_rcfg && !reconfig_busy_i)
					m_state <= RCFG_IDLE;
			end
			default: m_state <= RCFG_IDLE;
			endcase
		end
	end

	// blanking and arbiter models
	always @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			m_cnt <= 8'd0;
			m_hs <= 1'b0;
			m_vs <= 1'b0;
			m_r <= '0;
			m_g <= '0;
			m_b <= '0;
			m_stb <= 1'b0;
			m_act_q <= 1'b0;
			m_rdy <= 1'b0;
		end else begin
			if (!m_hs)
				m_cnt <= 8'd0;
			else if (!window_done(m_cnt))
				m_cnt <= m_cnt + 8'd1;
			if (ce_pix_i) begin
				m_hs <= hs_i;
				m_vs <= vs_i;
				m_r <= window_done(m_cnt) ? r_i : '0;
				m_g <= window_done(m_cnt) ? g_i : '0;
				m_b <= window_done(m_cnt) ? b_i : '0;
			end
			m_act_q <= loader_owns();
			if (m_act_q && !loader_owns())
				m_rdy <= 1'b1;
			// a write wins over an acknowledge
			m_stb <= loader_we_i ? 1'b1 : (ram_ack_i ? 1'b0 : m_stb);
		end
	end

	// outputs are compared half a cycle after the edge
	always @(negedge clk_sys) begin
		if (arst_n_i) begin
			check_bit("write_from_rom_o", write_from_rom_o, m_wr);
			check_bit("reconfig_o", reconfig_o, m_rcfg);
			check_bit("reconfig_reset_o", reconfig_reset_o, m_rrst);
			check_bit("vid_clk_ena_o", vid_clk_ena_o, m_vid);
			check_bit("rom_q_o", rom_q_o, family_rom_bit());
			check_bit("hs_o", hs_o, m_hs);
			check_bit("vs_o", vs_o, m_vs);
			check_colour("r_o", r_o, m_r);
			check_colour("g_o", g_o, m_g);
			check_colour("b_o", b_o, m_b);
			check_bit("scandoubler_en_o", scandoubler_en_o,
				!scandoubler_disable_i && tv_mode(clk_sel_i));
			check_bit("ram_stb_o", ram_stb_o, loader_owns() ? m_stb : core_stb_i);
			check_bit("ram_cyc_o", ram_cyc_o, loader_owns() ? m_stb : core_stb_i);
			check_bit("ram_we_o", ram_we_o, loader_owns() ? 1'b1 : core_we_i);
			check_sel("ram_sel_o", ram_sel_o, loader_owns() ? loader_sel_i : core_sel_i);
			check_ram_addr("ram_addr_o", ram_addr_o, loader_owns() ?
				ram_addr_t'({loader_addr_i[23:2], 2'b00}) :
				ram_addr_t'({core_addr_i[21:0], 2'b00}));
			check_word("ram_data_o", ram_data_o, loader_owns() ? loader_data_i : core_data_i);
			check_bit("core_ack_o", core_ack_o, loader_owns() ? 1'b0 : ram_ack_i);
			check_bit("rom_ready_o", rom_ready_o, m_rdy);
			check_bit("core_reset_o", core_reset_o, !ram_ready_i || !m_rdy || reset_button_i);
			check_bit("cmos_we_o", cmos_we_o,
				downloading_i && dio_index_i == IDX_CMOS && loader_we_i);
			check_bit("cmos_rd_o", cmos_rd_o, uploading_i && dio_index_i == IDX_CMOS);
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			report_counts();
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic randomize_video(input logic sel_moves);
		ce_pix_i <= chance(2);
		// long active lines, short sync pulses
		if (hs_i)
			hs_i <= !chance(400);
		else
			hs_i <= chance(8);
		vs_i <= vs_i ^ chance(50);
		r_i <= colour_t'($random(seed));
		g_i <= colour_t'($random(seed));
		b_i <= colour_t'($random(seed));
		scandoubler_disable_i <= scandoubler_disable_i ^ chance(300);
		rom_q24_i <= chance(2);
		rom_q25_i <= chance(2);
		rom_q36_i <= chance(2);
		if (sel_moves && chance(128))
			clk_sel_i <= clk_sel_t'($random(seed));
	endtask

	task automatic drive_loader(input logic dl, input logic ul, input dio_index_t idx);
		downloading_i <= dl;
		uploading_i <= ul;
		dio_index_i <= idx;
		loader_we_i <= chance(4);
		loader_addr_i <= loader_addr_t'($random(seed));
		loader_sel_i <= byte_sel_t'($random(seed));
		loader_data_i <= word_t'($random(seed));
	endtask

	task automatic core_traffic();
		core_stb_i <= chance(2);
		core_we_i <= chance(2);
		core_sel_i <= byte_sel_t'($random(seed));
		core_addr_i <= core_addr_t'($random(seed));
		core_data_i <= word_t'($random(seed));
		// acknowledge comes after a random delay
		ram_ack_i <= chance(3);
		ram_ready_i <= ram_ready_i ^ chance(200);
		reset_button_i <= chance(100);
	endtask

	task automatic step_random(input logic sel_moves, input logic dl, input logic ul,
		input dio_index_t idx);
		@(posedge clk_sys);
		randomize_video(sel_moves);
		drive_loader(dl, ul, idx);
		core_traffic();
		reconfig_busy_i <= chance(2);
	endtask

	// engine stays busy after reconfig, expect the reset pulse
	task automatic run_timeout();
		int gap;
		@(posedge clk_sys);
		reconfig_busy_i <= 1'b0;
		@(negedge clk_sys);
		while (!vid_clk_ena_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		clk_sel_i <= clk_sel_i ^ 2'b01;
		@(negedge clk_sys);
		while (!reconfig_o)
			@(negedge clk_sys);
		@(posedge clk_sys);
		reconfig_busy_i <= 1'b1;
		@(negedge clk_sys);
		// one edge has passed since the reconfig pulse
		gap = 1;
		while (!reconfig_reset_o) begin
			gap++;
			@(negedge clk_sys);
		end
		if (gap != RECONFIG_TIMEOUT - 1) begin
			err_other++;
			$display("reconfig reset came %0d cycles after the reconfig pulse, expected %0d",
				gap, RECONFIG_TIMEOUT - 1);
		end
		// a fresh select must be taken after recovery
		@(posedge clk_sys);
		reconfig_busy_i <= 1'b0;
		clk_sel_i <= clk_sel_i ^ 2'b11;
		@(negedge clk_sys);
		while (!write_from_rom_o)
			@(negedge clk_sys);
	endtask

	initial begin
		arst_n_i = 1'b0;
		clk_sel_i = 2'b00;
		{reconfig_busy_i, rom_q24_i, rom_q25_i, rom_q36_i} = '0;
		{ce_pix_i, scandoubler_disable_i, hs_i, vs_i} = '0;
		{r_i, g_i, b_i} = '0;
		{downloading_i, uploading_i, loader_we_i} = '0;
		dio_index_i = '0;
		loader_addr_i = '0;
		loader_sel_i = '0;
		loader_data_i = '0;
		{core_stb_i, core_we_i} = '0;
		core_sel_i = '0;
		core_addr_i = '0;
		core_data_i = '0;
		ram_ack_i = 1'b0;
		ram_ready_i = 1'b1;
		reset_button_i = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk_sys);
		arst_n_i <= 1'b1;

		repeat (SEQ_CYCLES)
			step_random(1'b1, 1'b0, 1'b0, 8'd0);
		repeat (TIMEOUT_RUNS)
			run_timeout();

		repeat (LOAD_CYCLES)
			step_random(1'b0, 1'b1, 1'b0, IDX_ROM_A);
		repeat (LOAD_CYCLES)
			step_random(1'b0, 1'b1, 1'b0, IDX_ROM_B);
		repeat (CMOS_CYCLES)
			step_random(1'b0, 1'b1, 1'b0, IDX_CMOS);
		repeat (CMOS_CYCLES)
			step_random(1'b0, 1'b0, 1'b1, IDX_CMOS);
		@(negedge clk_sys);
		if (!rom_ready_o) begin
			err_other++;
			$display("rom_ready_o is still low after the ROM download ended");
		end

		repeat (CORE_CYCLES)
			step_random(1'b1, 1'b0, 1'b0, 8'd0);
		@(negedge clk_sys);

		report_counts();
		if (total_errors() == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
